// File: src.f
+incdir+.
lsu_pkg.sv
load_queue.sv
store_queue.sv
mem_port_arbiter.sv
lsu_top.sv
tb_lsu.sv

// File: Makefile
# Verilator simulation of the load/store unit testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_lsu -Mdir obj_dir

run: compile
	./obj_dir/Vtb_lsu | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_lsu_model.svh
// Testbench reference model
`ifndef TB_LSU_MODEL_SVH
`define TB_LSU_MODEL_SVH

// Fibonacci LFSR state, taps 16, 14, 13 and 11
logic [15:0] lfsr_q = 16'd75;

// One LFSR step per bit taken, first bit ends up on top
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        r      = {r[30:0], fb};
    end
    return r;
endfunction

// Memory content, a mix of every word address bit
function automatic logic [31:0] mem_word(input logic [31:0] adr);
    logic [29:0] wa;
    wa = adr[31:2];
    return {wa[15:0], wa[29:14]} ^ (wa * 32'h9E37_79B1);
endfunction

function automatic logic [31:0] eff_addr(input logic [31:0] base, input logic [11:0] imm);
    return base + {{20{imm[11]}}, imm};
endfunction

// Lane pick by offset, then sign or zero extension
function automatic logic [31:0] exp_load(input lsu_pkg::ldst_type_e ty,
                                         input logic [31:0] adr);
    logic [31:0] lane;
    lane = mem_word(adr) >> {adr[1:0], 3'b000};
    case (ty)
        lsu_pkg::LS_BYTE:   return {{24{lane[7]}}, lane[7:0]};
        lsu_pkg::LS_BYTE_U: return {24'h0, lane[7:0]};
        lsu_pkg::LS_HALF:   return {{16{lane[15]}}, lane[15:0]};
        lsu_pkg::LS_HALF_U: return {16'h0, lane[15:0]};
        default:            return lane;
    endcase
endfunction

function automatic logic [3:0] exp_sel(input lsu_pkg::ldst_type_e ty, input logic [1:0] off);
    case (ty)
        lsu_pkg::LS_BYTE, lsu_pkg::LS_BYTE_U: return 4'b0001 << off;
        lsu_pkg::LS_HALF, lsu_pkg::LS_HALF_U: return 4'b0011 << off;
        default:                              return 4'b1111;
    endcase
endfunction

function automatic logic [31:0] lane_mask(input logic [3:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
endfunction

`endif

// File: tb_lsu.sv
// Load/store unit testbench

`timescale 1ns/100ps

module tb_lsu;

    localparam int N_ACC   = 200;
    localparam int TIMEOUT = 2 * N_ACC * 6 + 200;

    logic                   clk_i;
    logic                   reset_i;
    logic                   ld_issue_valid_i;
    lsu_pkg::issue_t        ld_issue_i;
    logic                   ld_issue_ready_o;
    logic                   st_issue_valid_i;
    lsu_pkg::issue_t        st_issue_i;
    logic                   st_issue_ready_o;
    logic                   result_valid_o;
    lsu_pkg::load_result_t  result_o;
    logic                   result_ready_i;
    logic                   wb_cyc_o;
    logic                   wb_stb_o;
    logic                   wb_we_o;
    logic [31:0]            wb_adr_o;
    logic [31:0]            wb_dat_o;
    logic [3:0]             wb_sel_o;
    logic [31:0]            wb_dat_i;
    logic                   wb_ack_i;

    // Expected accesses in issue order
    logic [31:0]            st_exp_adr [$];
    logic [3:0]             st_exp_sel [$];
    logic [31:0]            st_exp_dat [$];
    logic [3:0]             ld_exp_tag [$];
    logic [31:0]            ld_exp_val [$];

    int                     ld_sent;
    int                     st_sent;
    int                     ld_returned;
    int                     st_acked;
    int                     cycle_cnt;
    int                     wait_left;
    lsu_pkg::mem_req_t      bus_q;
    lsu_pkg::load_result_t  res_q;
    logic                   pend_q;
    logic                   hold_q;
    logic                   cyc_q;
    logic                   both_req_q;
    logic                   last_we;
    logic                   have_owner;
    logic                   ld_stall_seen;
    logic                   st_stall_seen;

    `include "tb_lsu_model.svh"

    lsu_top #(
        .LQ_DEPTH (4),
        .SQ_DEPTH (4)
    ) i_lsu_top (.*);

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    endtask

    // Random access, naturally aligned, in the lower or upper address half
    function automatic lsu_pkg::issue_t make_issue(input logic upper);
        lsu_pkg::issue_t it;
        logic [31:0]     r;
        logic [31:0]     addr;
        r = rand_bits(3) % 32'd5;
        it.ldst_type = lsu_pkg::ldst_type_e'(r[2:0]);
        r    = rand_bits(31);
        addr = {upper, r[30:0]};
        if (it.ldst_type == lsu_pkg::LS_WORD) begin
            addr[1:0] = 2'b00;
        end else if (it.ldst_type == lsu_pkg::LS_HALF || it.ldst_type == lsu_pkg::LS_HALF_U) begin
            addr[0] = 1'b0;
        end
        r       = rand_bits(12);
        it.imm  = r[11:0];
        it.base = addr - {{20{it.imm[11]}}, it.imm};
        it.data = rand_bits(32);
        r       = rand_bits(4);
        it.tag  = r[3:0];
        return it;
    endfunction

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Issue drivers, result back-pressure and the Wishbone slave
    always @(posedge clk_i) begin : drive
        logic [31:0] ea;
        if (!reset_i) begin
            if (ld_issue_valid_i && ld_issue_ready_o) begin
                ea = eff_addr(ld_issue_i.base, ld_issue_i.imm);
                ld_exp_tag.push_back(ld_issue_i.tag);
                ld_exp_val.push_back(exp_load(ld_issue_i.ldst_type, ea));
                ld_sent++;
            end
            if (!ld_issue_valid_i || ld_issue_ready_o) begin
                if (ld_sent < N_ACC && rand_bits(2) != 0) begin
                    ld_issue_i       <= make_issue(1'b0);
                    ld_issue_valid_i <= 1'b1;
                end else begin
                    ld_issue_valid_i <= 1'b0;
                end
            end
            if (st_issue_valid_i && st_issue_ready_o) begin
                ea = eff_addr(st_issue_i.base, st_issue_i.imm);
                st_exp_adr.push_back({ea[31:2], 2'b00});
                st_exp_sel.push_back(exp_sel(st_issue_i.ldst_type, ea[1:0]));
                st_exp_dat.push_back(st_issue_i.data << {ea[1:0], 3'b000});
                st_sent++;
            end
            if (!st_issue_valid_i || st_issue_ready_o) begin
                if (st_sent < N_ACC && rand_bits(2) != 0) begin
                    st_issue_i       <= make_issue(1'b1);
                    st_issue_valid_i <= 1'b1;
                end else begin
                    st_issue_valid_i <= 1'b0;
                end
            end
            result_ready_i <= (rand_bits(2) != 0);
            // Slave acks after 0 to 3 wait states
            if (wb_ack_i) begin
                wb_ack_i <= 1'b0;
            end else if (wb_cyc_o && wb_stb_o) begin
                if (wait_left < 0) begin
                    wait_left = rand_bits(2);
                end
                if (wait_left == 0) begin
                    wb_ack_i <= 1'b1;
                    if (!wb_we_o) begin
                        wb_dat_i <= mem_word(wb_adr_o);
                    end
                    wait_left = -1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    always @(posedge clk_i) begin : monitor
        lsu_pkg::mem_req_t cur;
        logic [31:0]       mask;
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            stop_run($sformatf("Timeout after %0d cycles with accesses still outstanding",
                               cycle_cnt));
        end
        if (!reset_i) begin
            cur = '{addr: wb_adr_o, wdata: wb_dat_o, sel: wb_sel_o, we: wb_we_o};
            assert (!wb_stb_o || wb_cyc_o) else stop_run("Wishbone stb is high without cyc");
            if (pend_q) begin
                assert (wb_cyc_o && wb_stb_o) else stop_run("cyc or stb fell before ack");
                assert (cur == bus_q) else stop_run("Wishbone outputs changed before ack");
            end
            if (wb_cyc_o && wb_stb_o && wb_ack_i && wb_we_o) begin
                assert (st_exp_adr.size() > 0) else stop_run("Write seen with no store pending");
                mask = lane_mask(st_exp_sel[0]);
                assert (wb_adr_o == st_exp_adr[0])
                    else report_mismatch("store_addr", st_exp_adr[0], wb_adr_o);
                assert (wb_sel_o == st_exp_sel[0])
                    else report_mismatch("store_sel", 32'(st_exp_sel[0]), 32'(wb_sel_o));
                assert ((wb_dat_o & mask) == (st_exp_dat[0] & mask))
                    else report_mismatch("store_data", st_exp_dat[0] & mask, wb_dat_o & mask);
                void'(st_exp_adr.pop_front());
                void'(st_exp_sel.pop_front());
                void'(st_exp_dat.pop_front());
                st_acked++;
            end
            // A new cycle starts one edge after its grant
            if (wb_cyc_o && !cyc_q) begin
                if (both_req_q && have_owner) begin
                    assert (wb_we_o != last_we)
                        else stop_run("Same queue granted twice in a row while both waited");
                end
                last_we    = wb_we_o;
                have_owner = 1'b1;
            end
            if (hold_q) begin
                assert (result_valid_o) else stop_run("Result valid fell while ready was low");
                assert (result_o == res_q) else stop_run("Held result changed while ready was low");
            end
            if (result_valid_o && result_ready_i) begin
                assert (ld_exp_tag.size() > 0) else stop_run("Load result with no load pending");
                assert (result_o.tag == ld_exp_tag[0])
                    else report_mismatch("load_tag", 32'(ld_exp_tag[0]), 32'(result_o.tag));
                assert (result_o.value == ld_exp_val[0])
                    else report_mismatch("load_value", ld_exp_val[0], result_o.value);
                void'(ld_exp_tag.pop_front());
                void'(ld_exp_val.pop_front());
                ld_returned++;
            end
            ld_stall_seen = ld_stall_seen || !ld_issue_ready_o;
            st_stall_seen = st_stall_seen || !st_issue_ready_o;
            pend_q     = wb_stb_o && !wb_ack_i;
            bus_q      = cur;
            hold_q     = result_valid_o && !result_ready_i;
            res_q      = result_o;
            cyc_q      = wb_cyc_o;
            both_req_q = i_lsu_top.ld_req_valid && i_lsu_top.st_req_valid;
        end
    end

    initial begin
        reset_i          = 1'b1;
        ld_issue_valid_i = 1'b0;
        ld_issue_i       = '0;
        st_issue_valid_i = 1'b0;
        st_issue_i       = '0;
        result_ready_i   = 1'b0;
        wb_dat_i         = '0;
        wb_ack_i         = 1'b0;
        ld_sent          = 0;
        st_sent          = 0;
        ld_returned      = 0;
        st_acked         = 0;
        cycle_cnt        = 0;
        wait_left        = -1;
        pend_q           = 1'b0;
        hold_q           = 1'b0;
        cyc_q            = 1'b0;
        both_req_q       = 1'b0;
        last_we          = 1'b0;
        have_owner       = 1'b0;
        ld_stall_seen    = 1'b0;
        st_stall_seen    = 1'b0;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        while (ld_returned < N_ACC || st_acked < N_ACC) begin
            @(posedge clk_i);
        end
        if (ld_stall_seen && st_stall_seen) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            stop_run("An issue ready output never fell under load");
        end
    end

endmodule

// File: lsu_top.sv
// Load/store unit top level

`timescale 1ns/100ps

module lsu_top #(
    parameter int LQ_DEPTH = 4,
    parameter int SQ_DEPTH = 4
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        ld_issue_valid_i,
    input  lsu_pkg::issue_t             ld_issue_i,
    output logic                        ld_issue_ready_o,
    input  logic                        st_issue_valid_i,
    input  lsu_pkg::issue_t             st_issue_i,
    output logic                        st_issue_ready_o,
    output logic                        result_valid_o,
    output lsu_pkg::load_result_t       result_o,
    input  logic                        result_ready_i,
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output logic [lsu_pkg::XLEN-1:0]    wb_adr_o,
    output logic [lsu_pkg::XLEN-1:0]    wb_dat_o,
    output logic [lsu_pkg::SEL_W-1:0]   wb_sel_o,
    input  logic [lsu_pkg::XLEN-1:0]    wb_dat_i,
    input  logic                        wb_ack_i
);

    logic                       ld_req_valid;
    lsu_pkg::mem_req_t          ld_req;
    logic                       ld_done;
    logic                       st_req_valid;
    lsu_pkg::mem_req_t          st_req;
    logic                       st_done;
    logic [lsu_pkg::XLEN-1:0]   mem_rdata;

    load_queue #(
        .LQ_DEPTH (LQ_DEPTH)
    ) i_load_queue (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .issue_valid_i   (ld_issue_valid_i),
        .issue_i         (ld_issue_i),
        .issue_ready_o   (ld_issue_ready_o),
        .mem_req_valid_o (ld_req_valid),
        .mem_req_o       (ld_req),
        .mem_done_i      (ld_done),
        .mem_rdata_i     (mem_rdata),
        .result_valid_o  (result_valid_o),
        .result_o        (result_o),
        .result_ready_i  (result_ready_i)
    );

    store_queue #(
        .SQ_DEPTH (SQ_DEPTH)
    ) i_store_queue (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .issue_valid_i   (st_issue_valid_i),
        .issue_i         (st_issue_i),
        .issue_ready_o   (st_issue_ready_o),
        .mem_req_valid_o (st_req_valid),
        .mem_req_o       (st_req),
        .mem_done_i      (st_done)
    );

    // Shared data memory port
    mem_port_arbiter i_mem_port_arbiter (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .ld_req_valid_i (ld_req_valid),
        .ld_req_i       (ld_req),
        .st_req_valid_i (st_req_valid),
        .st_req_i       (st_req),
        .ld_done_o      (ld_done),
        .st_done_o      (st_done),
        .rdata_o        (mem_rdata),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_we_o        (wb_we_o),
        .wb_adr_o       (wb_adr_o),
        .wb_dat_o       (wb_dat_o),
        .wb_sel_o       (wb_sel_o),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_i       (wb_ack_i)
    );

endmodule

// File: mem_port_arbiter.sv
// Wishbone port arbiter
// Round-robin grant and acknowledge steering

`timescale 1ns/100ps

module mem_port_arbiter (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        ld_req_valid_i,
    input  lsu_pkg::mem_req_t           ld_req_i,
    input  logic                        st_req_valid_i,
    input  lsu_pkg::mem_req_t           st_req_i,
    output logic                        ld_done_o,
    output logic                        st_done_o,
    output logic [lsu_pkg::XLEN-1:0]    rdata_o,
    output logic                        wb_cyc_o,
    output logic                        wb_stb_o,
    output logic                        wb_we_o,
    output logic [lsu_pkg::XLEN-1:0]    wb_adr_o,
    output logic [lsu_pkg::XLEN-1:0]    wb_dat_o,
    output logic [lsu_pkg::SEL_W-1:0]   wb_sel_o,
    input  logic [lsu_pkg::XLEN-1:0]    wb_dat_i,
    input  logic                        wb_ack_i
);

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_e;

    arb_state_e                 state_q;
    lsu_pkg::mem_req_t          req_q;
    logic                       owner_st_q;
    logic                       ld_pref_q;
    logic                       ld_done_q;
    logic                       st_done_q;
    logic [lsu_pkg::XLEN-1:0]   rdata_q;
    logic                       ld_elig;
    logic                       st_elig;
    logic                       grant_ld;
    logic                       grant_st;

    // A requester whose done is pulsing still shows its old request
    assign ld_elig = ld_req_valid_i && !ld_done_q;
    assign st_elig = st_req_valid_i && !st_done_q;

    assign grant_ld = (state_q == ARB_IDLE) && ld_elig && (ld_pref_q || !st_elig);
    assign grant_st = (state_q == ARB_IDLE) && st_elig && !grant_ld;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q    <= ARB_IDLE;
            owner_st_q <= 1'b0;
            ld_pref_q  <= 1'b1;
            ld_done_q  <= 1'b0;
            st_done_q  <= 1'b0;
        end else begin
            ld_done_q <= 1'b0;
            st_done_q <= 1'b0;
            case (state_q)
                ARB_IDLE: begin
                    if (grant_ld || grant_st) begin
                        state_q    <= ARB_BUSY;
                        owner_st_q <= grant_st;
                        // Next time the other side goes first
                        ld_pref_q  <= grant_st;
                    end
                end
                ARB_BUSY: begin
                    if (wb_ack_i) begin
                        state_q   <= ARB_IDLE;
                        ld_done_q <= !owner_st_q;
                        st_done_q <= owner_st_q;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // Latched request drives the bus for the whole access
    always_ff @(posedge clk_i) begin
        if (grant_ld) begin
            req_q <= ld_req_i;
        end else if (grant_st) begin
            req_q <= st_req_i;
        end
        if ((state_q == ARB_BUSY) && wb_ack_i) begin
            rdata_q <= wb_dat_i;
        end
    end

    assign wb_cyc_o = (state_q == ARB_BUSY);
    assign wb_stb_o = (state_q == ARB_BUSY);
    assign wb_we_o  = req_q.we;
    assign wb_adr_o = {req_q.addr[lsu_pkg::XLEN-1:2], 2'b00};
    assign wb_dat_o = req_q.wdata;
    assign wb_sel_o = req_q.sel;

    assign ld_done_o = ld_done_q;
    assign st_done_o = st_done_q;
    assign rdata_o   = rdata_q;

    // Strobe only inside a cycle, master outputs frozen until ack
    a_wb_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && wb_cyc_o && $stable(wb_we_o) &&
        $stable(wb_adr_o) && $stable(wb_dat_o) && $stable(wb_sel_o));

endmodule

// File: store_queue.sv
// Store queue
// Pending stores with byte lane placement

`timescale 1ns/100ps

module store_queue #(
    parameter int SQ_DEPTH = 4
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                issue_valid_i,
    input  lsu_pkg::issue_t     issue_i,
    output logic                issue_ready_o,
    output logic                mem_req_valid_o,
    output lsu_pkg::mem_req_t   mem_req_o,
    input  logic                mem_done_i
);

    localparam int IDX_W = $clog2(SQ_DEPTH);

    lsu_pkg::mem_req_t          sq_mem [SQ_DEPTH];
    logic [IDX_W:0]             wr_ptr_q;
    logic [IDX_W:0]             rd_ptr_q;
    logic                       full;
    logic                       empty;
    logic                       push;
    logic [lsu_pkg::XLEN-1:0]   st_addr;
    logic [lsu_pkg::SEL_W-1:0]  st_sel;

    assign full  = (wr_ptr_q[IDX_W] != rd_ptr_q[IDX_W]) &&
                   (wr_ptr_q[IDX_W-1:0] == rd_ptr_q[IDX_W-1:0]);
    assign empty = (wr_ptr_q == rd_ptr_q);
    assign push  = issue_valid_i && issue_ready_o;

    assign issue_ready_o = !full;
    assign st_addr = issue_i.base +
                     {{(lsu_pkg::XLEN-lsu_pkg::IMM_W){issue_i.imm[lsu_pkg::IMM_W-1]}}, issue_i.imm};

    // One lane for bytes, two for halves, all four for words
    always_comb begin
        case (issue_i.ldst_type)
            lsu_pkg::LS_BYTE, lsu_pkg::LS_BYTE_U: st_sel = 4'b0001 << st_addr[1:0];
            lsu_pkg::LS_HALF, lsu_pkg::LS_HALF_U: st_sel = 4'b0011 << st_addr[1:0];
            default:                              st_sel = 4'b1111;
        endcase
    end

    // The entry is kept as the finished bus request
    always_ff @(posedge clk_i) begin
        if (push) begin
            sq_mem[wr_ptr_q[IDX_W-1:0]] <= '{addr:  st_addr,
                                            wdata: issue_i.data << {st_addr[1:0], 3'b000},
                                            sel:   st_sel,
                                            we:    1'b1};
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            // Head retires once memory has taken it
            if (mem_done_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    assign mem_req_valid_o = !empty;
    assign mem_req_o       = sq_mem[rd_ptr_q[IDX_W-1:0]];

    a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
        full && !mem_done_i |=> $stable(wr_ptr_q));

endmodule

// File: load_queue.sv
// Load queue
// Pending loads, address generation and load data extraction

`timescale 1ns/100ps

module load_queue #(
    parameter int LQ_DEPTH = 4
) (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   issue_valid_i,
    input  lsu_pkg::issue_t        issue_i,
    output logic                   issue_ready_o,
    output logic                   mem_req_valid_o,
    output lsu_pkg::mem_req_t      mem_req_o,
    input  logic                   mem_done_i,
    input  logic [lsu_pkg::XLEN-1:0] mem_rdata_i,
    output logic                   result_valid_o,
    output lsu_pkg::load_result_t  result_o,
    input  logic                   result_ready_i
);

    localparam int IDX_W = $clog2(LQ_DEPTH);

    typedef struct packed {
        lsu_pkg::ldst_type_e            ldst_type;
        logic [lsu_pkg::XLEN-1:0]       addr;
        logic [lsu_pkg::TAG_W-1:0]      tag;
    } lq_entry_t;

    lq_entry_t                  lq_mem [LQ_DEPTH];
    lq_entry_t                  head;
    logic [IDX_W:0]             wr_ptr_q;
    logic [IDX_W:0]             rd_ptr_q;
    logic                       full;
    logic                       empty;
    logic                       push;
    logic                       pop;
    logic [lsu_pkg::XLEN-1:0]   imm_ext;
    logic [lsu_pkg::XLEN-1:0]   lane_data;
    logic [lsu_pkg::XLEN-1:0]   ext_value;
    logic                       res_valid_q;
    lsu_pkg::load_result_t      res_q;

    assign full  = (wr_ptr_q[IDX_W] != rd_ptr_q[IDX_W]) &&
                   (wr_ptr_q[IDX_W-1:0] == rd_ptr_q[IDX_W-1:0]);
    assign empty = (wr_ptr_q == rd_ptr_q);
    assign push  = issue_valid_i && issue_ready_o;
    assign pop   = res_valid_q && result_ready_i;

    assign issue_ready_o = !full;
    assign imm_ext = {{(lsu_pkg::XLEN-lsu_pkg::IMM_W){issue_i.imm[lsu_pkg::IMM_W-1]}}, issue_i.imm};

    // Address is formed once, on entry
    always_ff @(posedge clk_i) begin
        if (push) begin
            lq_mem[wr_ptr_q[IDX_W-1:0]] <= '{ldst_type: issue_i.ldst_type,
                                            addr:      issue_i.base + imm_ext,
                                            tag:       issue_i.tag};
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    assign head = lq_mem[rd_ptr_q[IDX_W-1:0]];

    // Head reads the whole word, stalls while a result waits
    assign mem_req_valid_o = !empty && !res_valid_q;
    assign mem_req_o = '{addr: head.addr, wdata: '0, sel: '1, we: 1'b0};

    // Lane selection by the low address bits, then extension by type
    always_comb begin
        lane_data = mem_rdata_i >> {head.addr[1:0], 3'b000};
        case (head.ldst_type)
            lsu_pkg::LS_BYTE:   ext_value = {{(lsu_pkg::XLEN-8){lane_data[7]}}, lane_data[7:0]};
            lsu_pkg::LS_BYTE_U: ext_value = {{(lsu_pkg::XLEN-8){1'b0}}, lane_data[7:0]};
            lsu_pkg::LS_HALF:   ext_value = {{(lsu_pkg::XLEN-16){lane_data[15]}}, lane_data[15:0]};
            lsu_pkg::LS_HALF_U: ext_value = {{(lsu_pkg::XLEN-16){1'b0}}, lane_data[15:0]};
            default:            ext_value = mem_rdata_i;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            res_valid_q <= 1'b0;
        end else if (mem_done_i) begin
            res_valid_q <= 1'b1;
        end else if (pop) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_done_i) begin
            res_q <= '{tag: head.tag, value: ext_value};
        end
    end

    assign result_valid_o = res_valid_q;
    assign result_o       = res_q;

    // A full queue keeps its write pointer until an entry leaves
    a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
        full && !pop |=> $stable(wr_ptr_q));

endmodule

// File: lsu_pkg.sv
// Load/store unit shared types

package lsu_pkg;

    // Data path and address width
    localparam int XLEN  = 32;
    localparam int TAG_W = 4;
    localparam int SEL_W = XLEN / 8;
    localparam int IMM_W = 12;

    // Access width and signedness
    typedef enum logic [2:0] {
        LS_BYTE   = 3'd0,
        LS_BYTE_U = 3'd1,
        LS_HALF   = 3'd2,
        LS_HALF_U = 3'd3,
        LS_WORD   = 3'd4
    } ldst_type_e;

    // One instruction from the issue stage, 83 bits
    typedef struct packed {
        ldst_type_e         ldst_type;
        logic [XLEN-1:0]    base;
        logic [IMM_W-1:0]   imm;
        logic [XLEN-1:0]    data;
        logic [TAG_W-1:0]   tag;
    } issue_t;

    // One memory access as a queue presents it, 69 bits
    typedef struct packed {
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    wdata;
        logic [SEL_W-1:0]   sel;
        logic               we;
    } mem_req_t;

    // Finished load, 36 bits
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [XLEN-1:0]    value;
    } load_result_t;

endpackage
